/* Bender.yml */
package:
  name: sdram_stats

dependencies: {}

sources:
  # Packages first, shared by RTL and testbench
  - sdram_cmd_pkg.sv
  - sdram_stats_pkg.sv
  # Statistics blocks
  - sdram_stats_bank.sv
  - sdram_cmd_counter.sv
  - sdram_stats_readout.sv
  # Top level
  - sdram_stats.sv
  # Testbench
  - target: test
    files:
      - tb_sdram_stats.sv

/* sdram_cmd_counter.sv */
// SDRAM command counter: saturating bus-wide counts of READ, WRITE, REFRESH and PRECHARGE
`timescale 1ns/1ps

module sdram_cmd_counter #(
    parameter int CNT_W = 32  // Counter width
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                clr,         // Synchronous clear
    input  sdram_cmd_pkg::cmd_t cmd,         // Decoded pin word, active low bits
    output logic [CNT_W-1:0]    reads,
    output logic [CNT_W-1:0]    writes,
    output logic [CNT_W-1:0]    refreshes,
    output logic [CNT_W-1:0]    precharges
);

    logic is_read;
    logic is_write;
    logic is_refresh;
    logic is_precharge;

    // Exact compares, so /CS high never matches
    assign is_read      = (cmd == sdram_cmd_pkg::CMD_READ);
    assign is_write     = (cmd == sdram_cmd_pkg::CMD_WRITE);
    assign is_refresh   = (cmd == sdram_cmd_pkg::CMD_REFRESH);
    assign is_precharge = (cmd == sdram_cmd_pkg::CMD_PRECHARGE);

    // NOP, STOP, LOAD_MODE and ACTIVE fall through untouched

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reads      <= '0;
            writes     <= '0;
            refreshes  <= '0;
            precharges <= '0;
        end else if (clr) begin  // Command in the clear cycle is dropped
            reads      <= '0;
            writes     <= '0;
            refreshes  <= '0;
            precharges <= '0;
        end else begin
            // One command per cycle, at most one counter moves
            // Each holds at all ones instead of wrapping
            if (is_read && reads != '1) begin
                reads <= reads + 1'b1;
            end
            if (is_write && writes != '1) begin
                writes <= writes + 1'b1;
            end
            if (is_refresh && refreshes != '1) begin
                refreshes <= refreshes + 1'b1;
            end
            if (is_precharge && precharges != '1) begin
                precharges <= precharges + 1'b1;
            end
        end
    end

endmodule

/* sdram_cmd_pkg.sv */
// SDRAM command package: pin-group widths, command word type and truth-table codes
package sdram_cmd_pkg;

    // Pin group widths
    localparam int CMD_W     = 4;          // /CS /RAS /CAS /WE
    localparam int BA_W      = 2;          // Bank address pins
    localparam int NUM_BANKS = 1 << BA_W;  // 4 banks on a standard part

    // Command word as seen on the pins, all bits active low
    // Order is {ncs, nras, ncas, nwe}
    typedef logic [CMD_W-1:0] cmd_t;

    // Bank select
    typedef logic [BA_W-1:0] ba_t;

    // Standard SDRAM truth table
    //                                  /CS /RAS /CAS /WE
    localparam cmd_t CMD_LOAD_MODE = 4'b0_0_0_0;  // Mode register set
    localparam cmd_t CMD_REFRESH   = 4'b0_0_0_1;  // Auto refresh
    localparam cmd_t CMD_PRECHARGE = 4'b0_0_1_0;  // One bank or all, per A10
    localparam cmd_t CMD_ACTIVE    = 4'b0_0_1_1;  // Open a row
    localparam cmd_t CMD_WRITE     = 4'b0_1_0_0;
    localparam cmd_t CMD_READ      = 4'b0_1_0_1;
    localparam cmd_t CMD_STOP      = 4'b0_1_1_0;  // Burst terminate
    localparam cmd_t CMD_NOP       = 4'b0_1_1_1;

    // Device deselected
    // Any word with /CS high means inhibit, the low three bits are don't care,
    // so exact compares against the codes above already reject it
    localparam cmd_t CMD_INHIBIT   = 4'b1_0_0_0;

endpackage

/* sdram_stats.f */
sdram_cmd_pkg.sv
sdram_stats_pkg.sv
sdram_stats_bank.sv
sdram_cmd_counter.sv
sdram_stats_readout.sv
sdram_stats.sv
tb_sdram_stats.sv

/* sdram_stats.sv */
// SDRAM bus statistics monitor: decodes controller command pins and exposes counters by index
`timescale 1ns/1ps

module sdram_stats #(
    parameter int ROW_W = 13,  // Address bits compared as a row
    parameter int CNT_W = 32   // Width of every statistic
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  clr,         // One-cycle clear of all statistics
    // Command pins driven by the memory controller
    input  logic                  sdram_ncs,
    input  logic                  sdram_nras,
    input  logic                  sdram_ncas,
    input  logic                  sdram_nwe,
    input  sdram_cmd_pkg::ba_t    sdram_ba,
    input  logic [ROW_W-1:0]      sdram_a,
    // Read port
    input  sdram_stats_pkg::sel_t rd_sel,
    output logic [CNT_W-1:0]      rd_data
);

    sdram_cmd_pkg::cmd_t cmd;  // {ncs, nras, ncas, nwe}

    // Per-bank statistics toward the readout
    logic [CNT_W-1:0] act_count  [sdram_cmd_pkg::NUM_BANKS];
    logic [CNT_W-1:0] same_count [sdram_cmd_pkg::NUM_BANKS];
    logic [CNT_W-1:0] longest    [sdram_cmd_pkg::NUM_BANKS];

    // Bus-wide counts
    logic [CNT_W-1:0] reads;
    logic [CNT_W-1:0] writes;
    logic [CNT_W-1:0] refreshes;
    logic [CNT_W-1:0] precharges;

    assign cmd = {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe};  // Truth-table order

    // One watcher per bank, each with its own bank number
    sdram_stats_bank #(.BA(2'd0), .ROW_W(ROW_W), .CNT_W(CNT_W)) u_bank0 (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .cmd        (cmd),
        .sdram_ba   (sdram_ba),
        .sdram_a    (sdram_a),
        .act_count  (act_count[0]),
        .same_count (same_count[0]),
        .longest    (longest[0])
    );

    sdram_stats_bank #(.BA(2'd1), .ROW_W(ROW_W), .CNT_W(CNT_W)) u_bank1 (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .cmd        (cmd),
        .sdram_ba   (sdram_ba),
        .sdram_a    (sdram_a),
        .act_count  (act_count[1]),
        .same_count (same_count[1]),
        .longest    (longest[1])
    );

    sdram_stats_bank #(.BA(2'd2), .ROW_W(ROW_W), .CNT_W(CNT_W)) u_bank2 (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .cmd        (cmd),
        .sdram_ba   (sdram_ba),
        .sdram_a    (sdram_a),
        .act_count  (act_count[2]),
        .same_count (same_count[2]),
        .longest    (longest[2])
    );

    sdram_stats_bank #(.BA(2'd3), .ROW_W(ROW_W), .CNT_W(CNT_W)) u_bank3 (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .cmd        (cmd),
        .sdram_ba   (sdram_ba),
        .sdram_a    (sdram_a),
        .act_count  (act_count[3]),
        .same_count (same_count[3]),
        .longest    (longest[3])
    );

    // READ, WRITE, REFRESH, PRECHARGE totals
    sdram_cmd_counter #(.CNT_W(CNT_W)) u_cmd_counter (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .cmd        (cmd),
        .reads      (reads),
        .writes     (writes),
        .refreshes  (refreshes),
        .precharges (precharges)
    );

    // Registered read port, one cycle latency
    sdram_stats_readout #(.CNT_W(CNT_W)) u_readout (
        .clk        (clk),
        .rst        (rst),
        .rd_sel     (rd_sel),
        .act_count  (act_count),
        .same_count (same_count),
        .longest    (longest),
        .reads      (reads),
        .writes     (writes),
        .refreshes  (refreshes),
        .precharges (precharges),
        .rd_data    (rd_data)
    );

endmodule

/* sdram_stats_bank.sv */
// SDRAM bank statistics: activations, same-row reopens and longest same-row run of one bank
`timescale 1ns/1ps

module sdram_stats_bank #(
    parameter sdram_cmd_pkg::ba_t BA = '0,  // Bank this instance watches
    parameter int ROW_W = 13,               // Row address width
    parameter int CNT_W = 32                // Statistic width
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      clr,        // Synchronous clear of all statistics
    input  sdram_cmd_pkg::cmd_t       cmd,
    input  sdram_cmd_pkg::ba_t        sdram_ba,
    input  logic [ROW_W-1:0]          sdram_a,
    output logic [CNT_W-1:0]          act_count,  // ACTIVE commands to this bank
    output logic [CNT_W-1:0]          same_count, // ACTIVEs reopening the last row
    output logic [CNT_W-1:0]          longest     // Max run, in-progress run included
);

    logic             act;       // ACTIVE addressed to this bank
    logic             hit;       // Reopens the stored row
    logic             row_vld;   // A row has been seen since reset or clear
    logic [ROW_W-1:0] row;       // Last row opened in this bank
    logic [CNT_W-1:0] cur_run;   // Length of the run in progress
    logic [CNT_W-1:0] next_run;  // Run length after this activation

    assign act = (cmd == sdram_cmd_pkg::CMD_ACTIVE) && (sdram_ba == BA);
    assign hit = row_vld && (sdram_a == row);  // No hit before the first row

    // Run extends on a hit, restarts at one otherwise
    always_comb begin
        if (!hit) begin
            next_run = CNT_W'(1);
        end else if (cur_run == '1) begin
            next_run = cur_run;  // Saturated
        end else begin
            next_run = cur_run + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            act_count  <= '0;
            same_count <= '0;
            longest    <= '0;
            cur_run    <= '0;
            row_vld    <= 1'b0;
        end else if (clr) begin  // Clear wins over a command in the same cycle
            act_count  <= '0;
            same_count <= '0;
            longest    <= '0;
            cur_run    <= '0;
            row_vld    <= 1'b0;  // Forget the last row too
        end else if (act) begin
            if (act_count != '1) act_count <= act_count + 1'b1;
            if (hit && same_count != '1) begin
                same_count <= same_count + 1'b1;
            end
            cur_run <= next_run;
            row_vld <= 1'b1;
            // Track the maximum as the run grows, not only on a row change
            if (next_run > longest) longest <= next_run;
        end
    end

    // Last opened row, replaced only when a different row opens
    always_ff @(posedge clk) begin
        if (act && !clr && !hit) begin
            row <= sdram_a;  // New row opened
        end
    end

endmodule

/* sdram_stats_pkg.sv */
// Statistics register map package: readout index type and index of every statistic
package sdram_stats_pkg;

    localparam int SEL_W = 4;  // 16 readable statistics

    // Readout index
    typedef logic [SEL_W-1:0] sel_t;

    // Per-bank groups, bank number added to the base
    localparam sel_t SEL_ACT_BASE  = 4'd0;   // ACTIVE count, banks 0..3
    localparam sel_t SEL_SAME_BASE = 4'd4;   // Same-row ACTIVE count
    localparam sel_t SEL_LONG_BASE = 8;      // Longest same-row run

    // Bus-wide command counters
    localparam sel_t SEL_READS     = 4'd12;
    localparam sel_t SEL_WRITES    = 4'd13;
    localparam sel_t SEL_REFRESH   = 4'd14;
    localparam sel_t SEL_PRECHARGE = 4'd15;

endpackage

/* sdram_stats_readout.sv */
// Statistics readout: indexed multiplexer over all counters with a one-cycle registered output
`timescale 1ns/1ps

module sdram_stats_readout #(
    parameter int CNT_W = 32  // Statistic width
) (
    input  logic                 clk,
    input  logic                 rst,
    input  sdram_stats_pkg::sel_t rd_sel,  // Register map index
    // Per-bank statistics
    input  logic [CNT_W-1:0]     act_count  [sdram_cmd_pkg::NUM_BANKS],
    input  logic [CNT_W-1:0]     same_count [sdram_cmd_pkg::NUM_BANKS],
    input  logic [CNT_W-1:0]     longest    [sdram_cmd_pkg::NUM_BANKS],
    // Bus-wide statistics
    input  logic [CNT_W-1:0]     reads,
    input  logic [CNT_W-1:0]     writes,
    input  logic [CNT_W-1:0]     refreshes,
    input  logic [CNT_W-1:0]     precharges,
    output logic [CNT_W-1:0]     rd_data   // Value selected one edge earlier
);

    logic [CNT_W-1:0] sel_data;  // Mux output ahead of the register

    // Decode against the register map
    always_comb begin
        sel_data = '0;
        for (int b = 0; b < sdram_cmd_pkg::NUM_BANKS; b++) begin
            if (rd_sel == sdram_stats_pkg::sel_t'(sdram_stats_pkg::SEL_ACT_BASE + b)) begin
                sel_data = act_count[b];
            end
            if (rd_sel == sdram_stats_pkg::sel_t'(sdram_stats_pkg::SEL_SAME_BASE + b)) begin
                sel_data = same_count[b];
            end
            if (rd_sel == sdram_stats_pkg::sel_t'(sdram_stats_pkg::SEL_LONG_BASE + b)) begin
                sel_data = longest[b];
            end
        end
        // Bus-wide counters at fixed indexes
        case (rd_sel)
            sdram_stats_pkg::SEL_READS:     sel_data = reads;
            sdram_stats_pkg::SEL_WRITES:    sel_data = writes;
            sdram_stats_pkg::SEL_REFRESH:   sel_data = refreshes;
            sdram_stats_pkg::SEL_PRECHARGE: sel_data = precharges;
            default: ;  // Bank groups handled above
        endcase
    end

    // Output register keeps the wide mux off the output path
    // Counter values are taken as they stand before the sampling edge
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_data <= '0;
        end else begin
            rd_data <= sel_data;
        end
    end

endmodule

/* tb_sdram_stats.sv */
// SDRAM statistics monitor testbench: controller-like stimulus, reference model and assertions
`timescale 1ns/1ps

module tb_sdram_stats;

    localparam int ROW_W = 13;
    localparam int CNT_W = 16;  // Small enough to reach saturation
    localparam int NB    = sdram_cmd_pkg::NUM_BANKS;
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    logic                  clk;
    logic                  rst;
    logic                  clr;
    logic                  sdram_ncs;
    logic                  sdram_nras;
    logic                  sdram_ncas;
    logic                  sdram_nwe;
    sdram_cmd_pkg::ba_t    sdram_ba;
    logic [ROW_W-1:0]      sdram_a;
    sdram_stats_pkg::sel_t rd_sel;
    logic [CNT_W-1:0]      rd_data;

    // Reference model state
    logic [CNT_W-1:0] m_act  [NB];
    logic [CNT_W-1:0] m_same [NB];
    logic [CNT_W-1:0] m_long [NB];
    logic [CNT_W-1:0] m_run  [NB];
    logic             m_vld  [NB];
    logic [ROW_W-1:0] m_row  [NB];
    logic [CNT_W-1:0] m_rd;
    logic [CNT_W-1:0] m_wr;
    logic [CNT_W-1:0] m_ref;
    logic [CNT_W-1:0] m_pre;

    logic [CNT_W-1:0] exp_data;          // Value due one edge after this rd_sel
    logic             chk_en = 1'b0;
    logic [CNT_W-1:0] exp_q;             // exp_data as sampled at the rd_sel edge
    logic             chk_q  = 1'b0;
    logic [31:0]      rng    = 32'd14293;
    logic [ROW_W-1:0] row_pool [4] = '{13'h0000, 13'h0001, 13'h0a5a, 13'h1fff};  // Few rows

    sdram_stats #(.ROW_W(ROW_W), .CNT_W(CNT_W)) i_sdram_stats (
        .clk        (clk),
        .rst        (rst),
        .clr        (clr),
        .sdram_ncs  (sdram_ncs),
        .sdram_nras (sdram_nras),
        .sdram_ncas (sdram_ncas),
        .sdram_nwe  (sdram_nwe),
        .sdram_ba   (sdram_ba),
        .sdram_a    (sdram_a),
        .rd_sel     (rd_sel),
        .rd_data    (rd_data)
    );

    always #4 clk = ~clk;  // 8 ns period

    always @(posedge clk) begin
        exp_q <= exp_data;
        chk_q <= chk_en;
    end

    // rd_data after edge N+1 must equal the model value chosen at edge N
    property rd_matches_model;
        @(posedge clk) disable iff (rst) chk_q |-> (rd_data == exp_q);
    endproperty

    assert property (rd_matches_model)
        else fail_stop($sformatf("[ERROR] %0t rd_data expected %0h received %0h",
                                 $time, $sampled(exp_q), $sampled(rd_data)));

    task automatic fail_stop(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at first failure");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [CNT_W-1:0] sat_inc(input logic [CNT_W-1:0] v);
        return (v == CNT_MAX) ? v : v + 1'b1;  // Hold at all ones
    endfunction

    function automatic logic [CNT_W-1:0] model_value(input sdram_stats_pkg::sel_t sel);
        if (sel < sdram_stats_pkg::SEL_SAME_BASE) begin
            return m_act[sel - sdram_stats_pkg::SEL_ACT_BASE];
        end
        if (sel < sdram_stats_pkg::SEL_LONG_BASE) begin
            return m_same[sel - sdram_stats_pkg::SEL_SAME_BASE];
        end
        if (sel < sdram_stats_pkg::SEL_READS) begin
            return m_long[sel - sdram_stats_pkg::SEL_LONG_BASE];
        end
        case (sel)
            sdram_stats_pkg::SEL_READS:   return m_rd;
            sdram_stats_pkg::SEL_WRITES:  return m_wr;
            sdram_stats_pkg::SEL_REFRESH: return m_ref;
            default:                      return m_pre;
        endcase
    endfunction

    // Apply one bus cycle to the model
    task automatic model_apply(input sdram_cmd_pkg::cmd_t c, input sdram_cmd_pkg::ba_t ba,
                               input logic [ROW_W-1:0] a, input logic clear);
        if (clear) begin  // Clear drops the command as well
            for (int b = 0; b < NB; b++) begin
                m_act[b]  = '0;
                m_same[b] = '0;
                m_long[b] = '0;
                m_run[b]  = '0;
                m_vld[b]  = 1'b0;
            end
            m_rd  = '0;
            m_wr  = '0;
            m_ref = '0;
            m_pre = '0;
        end else begin
            case (c)
                sdram_cmd_pkg::CMD_ACTIVE: begin
                    m_act[ba] = sat_inc(m_act[ba]);
                    if (m_vld[ba] && m_row[ba] == a) begin  // Reopen of the held row
                        m_same[ba] = sat_inc(m_same[ba]);
                        m_run[ba]  = sat_inc(m_run[ba]);
                    end else begin
                        m_row[ba] = a;
                        m_vld[ba] = 1'b1;
                        m_run[ba] = 1;
                    end
                    if (m_run[ba] > m_long[ba]) m_long[ba] = m_run[ba];
                end
                sdram_cmd_pkg::CMD_READ:      m_rd  = sat_inc(m_rd);
                sdram_cmd_pkg::CMD_WRITE:     m_wr  = sat_inc(m_wr);
                sdram_cmd_pkg::CMD_REFRESH:   m_ref = sat_inc(m_ref);
                sdram_cmd_pkg::CMD_PRECHARGE: m_pre = sat_inc(m_pre);
                default: ;  // NOP, STOP, mode load, inhibit
            endcase
        end
    endtask

    // One bus cycle, driven 1 ns after the rising edge
    task automatic drive(input sdram_cmd_pkg::cmd_t c, input sdram_cmd_pkg::ba_t ba,
                         input logic [ROW_W-1:0] a, input logic clear,
                         input sdram_stats_pkg::sel_t sel);
        @(posedge clk);
        #1;
        exp_data = model_value(sel);  // Stats before this command lands
        {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = c;
        sdram_ba = ba;
        sdram_a  = a;
        clr      = clear;
        rd_sel   = sel;
        chk_en   = 1'b1;
        model_apply(c, ba, a, clear);
    endtask

    task automatic read_all();
        for (int i = 0; i < 16; i++) begin
            drive(sdram_cmd_pkg::CMD_NOP, '0, '0, 1'b0, sdram_stats_pkg::sel_t'(i));
        end
    endtask

    initial begin
        sdram_cmd_pkg::cmd_t c;
        int                  wait_cnt;
        clk = 1'b0;
        rst = 1'b1;
        clr = 1'b0;
        {sdram_ncs, sdram_nras, sdram_ncas, sdram_nwe} = sdram_cmd_pkg::CMD_NOP;
        sdram_ba = '0;
        sdram_a  = '0;
        rd_sel   = '0;
        exp_data = '0;
        model_apply(sdram_cmd_pkg::CMD_NOP, '0, '0, 1'b1);  // Model starts cleared
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        read_all();  // Everything zero after reset

        // Bank 2: run of 3 on one row, then a run of 4 still open
        foreach (row_pool[k]) begin
            if (k < 2) begin
                repeat (k == 0 ? 3 : 4) begin
                    drive(sdram_cmd_pkg::CMD_ACTIVE, 2'd2, row_pool[k + 1], 1'b0, 4'd6);
                end
            end
        end
        read_all();

        // Bus-wide commands, each type a different number of times
        for (int n = 0; n < 4; n++) begin
            drive(sdram_cmd_pkg::CMD_PRECHARGE, '0, '0, 1'b0, sdram_stats_pkg::SEL_PRECHARGE);
            if (n < 3) drive(sdram_cmd_pkg::CMD_REFRESH, '0, '0, 1'b0, 4'd14);
            if (n < 2) drive(sdram_cmd_pkg::CMD_WRITE, '0, '0, 1'b0, 4'd13);
            if (n < 1) drive(sdram_cmd_pkg::CMD_READ, '0, '0, 1'b0, 4'd12);
        end
        for (int n = 0; n < 8; n++) begin  // /CS high over every low pattern
            drive(sdram_cmd_pkg::CMD_INHIBIT | sdram_cmd_pkg::cmd_t'(n), 2'(n), row_pool[0],
                  1'b0, 4'(n + 8));
        end
        drive(sdram_cmd_pkg::CMD_NOP, '0, '0, 1'b0, sdram_stats_pkg::SEL_READS);
        read_all();

        // Random stream, reads in rotation while commands keep landing
        for (int i = 0; i < 4000; i++) begin
            rng = xorshift(rng);
            case (rng[3:0])
                4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: c = sdram_cmd_pkg::CMD_ACTIVE;
                4'd6, 4'd7:  c = sdram_cmd_pkg::CMD_READ;
                4'd8:        c = sdram_cmd_pkg::CMD_WRITE;
                4'd9:        c = sdram_cmd_pkg::CMD_REFRESH;
                4'd10:       c = sdram_cmd_pkg::CMD_PRECHARGE;
                4'd11:       c = sdram_cmd_pkg::CMD_STOP;
                4'd12:       c = sdram_cmd_pkg::CMD_LOAD_MODE;
                4'd13:       c = sdram_cmd_pkg::CMD_INHIBIT | sdram_cmd_pkg::cmd_t'(rng[12:10]);
                default:     c = sdram_cmd_pkg::CMD_NOP;
            endcase
            drive(c, rng[5:4], row_pool[rng[9:8]], rng[31:24] == 8'd0,
                  sdram_stats_pkg::sel_t'(i));
        end

        // Clear together with an ACTIVE, then reopen the same row
        drive(sdram_cmd_pkg::CMD_ACTIVE, 2'd1, row_pool[2], 1'b0, 4'd1);
        drive(sdram_cmd_pkg::CMD_ACTIVE, 2'd1, row_pool[2], 1'b0, 4'd5);
        drive(sdram_cmd_pkg::CMD_ACTIVE, 2'd1, row_pool[2], 1'b1, 4'd9);
        drive(sdram_cmd_pkg::CMD_ACTIVE, 2'd1, row_pool[2], 1'b0, 4'd5);
        read_all();

        // Saturation of the READ counter
        wait_cnt = 0;
        while (m_rd != CNT_MAX) begin
            drive(sdram_cmd_pkg::CMD_READ, '0, '0, 1'b0, sdram_stats_pkg::SEL_READS);
            wait_cnt++;
            if (wait_cnt > 70000) fail_stop("Timeout: READ count never reached saturation");
        end
        wait_cnt = 0;
        do begin
            drive(sdram_cmd_pkg::CMD_READ, '0, '0, 1'b0, sdram_stats_pkg::SEL_READS);
            wait_cnt++;
            if (wait_cnt > 8) fail_stop("Timeout: rd_data never showed the saturated READ count");
        end while (rd_data != CNT_MAX);
        repeat (16) drive(sdram_cmd_pkg::CMD_READ, '0, '0, 1'b0, sdram_stats_pkg::SEL_READS);
        read_all();
        drive(sdram_cmd_pkg::CMD_NOP, '0, '0, 1'b0, '0);  // Let the last read be checked
        drive(sdram_cmd_pkg::CMD_NOP, '0, '0, 1'b0, '0);

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
